/* aer_params.svh */
/*
  Array and bus sizes for the AER readout.
  AER_ROW_AW and AER_COL_AW must equal clog2 of AER_HALF_ROWS and AER_COLS.
  The event word layout places the row at bits 5..4 and the column at 1..0,
  so the address widths must stay at 2 or that layout has to move.
  Two halves are assumed throughout, giving 2*AER_HALF_ROWS*AER_COLS pixels.
*/
`ifndef AER_PARAMS_SVH
`define AER_PARAMS_SVH

// Array geometry, per half
`define AER_HALF_ROWS 4
`define AER_COLS      4

// Encoded address widths
`define AER_ROW_AW    2
`define AER_COL_AW    2

// Wishbone data width
`define AER_WB_DW     32

`endif

/* aer_pkg.sv */
/*
  Shared types for the AER readout.
  Event word: bit 31 valid, bit 8 half (0 top, 1 bottom), bits 5..4 row,
  bits 1..0 column, all other bits zero. A word with valid = 0 is all zero.
  Control word at address 1: bit 0 enable, other bits read as zero.
  Widths come from aer_params.svh.
*/
`include "aer_params.svh"

package aer_pkg;

    typedef logic [`AER_HALF_ROWS-1:0] row_vec_t;   // One bit per row of a half
    typedef logic [`AER_COLS-1:0]      col_vec_t;   // One bit per column
    typedef logic [`AER_ROW_AW-1:0]    row_addr_t;  // Encoded row index
    typedef logic [`AER_COL_AW-1:0]    col_addr_t;  // Encoded column index
    typedef logic [`AER_WB_DW-1:0]     wb_data_t;   // Wishbone bus word

    // Merger holds at most one event
    typedef enum logic
    {
        MERGE_EMPTY = 1'b0,
        MERGE_FULL  = 1'b1
    } merge_state_t;

endpackage

/* priority_arb.sv */
/*
  Fixed-priority picker, purely combinational.
  Bit 0 has the highest priority. The grant is one-hot,
  or all zero when no request bit is set.
*/
`timescale 1ns/1ns

module priority_arb
#(
    parameter int WIDTH = 4                 // Number of requesters
)
(
    input  logic [WIDTH-1:0] req_i,         // Request bits
    output logic [WIDTH-1:0] gnt_o          // One-hot grant of lowest request
);

    logic [WIDTH-1:0] req_neg;              // Two's complement of the requests

    // Lowest set bit survives the and with its own negation
    assign req_neg = ~req_i + 1'b1;

    always_comb
    begin
        gnt_o = req_i & req_neg;
    end

endmodule

/* row_arbiter.sv */
/*
  Masked round-robin row arbiter for one half of the array.
  gnt_o and row_addr_o update one clock after a cycle with enable_i high.
  Each requesting row is granted once per round, rows ascending.
  An empty mask gives a zero grant and reloads to all ones, so a fresh
  enable is needed to start the next round.
  grp_release_o is registered: high one clock after a cycle with no masked request.
*/
`timescale 1ns/1ns

module row_arbiter
    import aer_pkg::*;
(
    input  logic      clk_i,                // Clock
    input  logic      reset_i,              // Asynchronous reset, active high
    input  logic      enable_i,             // Advance to the next row
    input  row_vec_t  req_i,                // Rows with pending pixels
    output row_vec_t  gnt_o,                // Registered one-hot row grant
    output row_addr_t row_addr_o,           // Encoded granted row
    output logic      grp_release_o         // Round finished, mask reloaded
);

    row_vec_t mask_q;                       // Rows still eligible this round
    row_vec_t mask_req;                     // Requests inside the mask
    row_vec_t mask_gnt;                     // Lowest masked request
    row_vec_t mask_next;                    // Rows strictly above the grant

    assign mask_req  = req_i & mask_q;
    assign mask_next = ~((mask_gnt << 1) - 1'b1);  // Top row grant leaves mask empty

    priority_arb #(.WIDTH($bits(row_vec_t))) u_pick
    (
        .req_i (mask_req),
        .gnt_o (mask_gnt)
    );

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_q        <= '1;            // All rows open
            gnt_o         <= '0;
            grp_release_o <= 1'b0;
        end
        else
        begin
            grp_release_o <= (mask_req == '0);
            if (enable_i)
            begin
                gnt_o <= mask_gnt;          // Zero when the round is exhausted
                if (mask_gnt == '0)
                    mask_q <= '1;           // Start a new round
                else
                    mask_q <= mask_next;
            end
        end
    end

    // Encode the registered grant, zero grant reads as row 0
    always_comb
    begin
        row_addr_o = '0;
        for (int i = 0; i < $bits(row_vec_t); i++)
        begin
            if (gnt_o[i])
                row_addr_o = row_addr_t'(i);
        end
    end

    a_gnt_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o))
        else $error("row grant is not one-hot: %b", gnt_o);

endmodule

/* half_readout.sv */
/*
  Readout of one half of the pixel array.
  Pixels hold a level request until their clear pulse, which comes one
  clock after the take. Columns of the granted row are served ascending;
  a column served in this row visit waits for the next round.
  The offer stays valid with a fixed address until the merger takes it.
  No new offer and no row advance while enable_i is low.
*/
`timescale 1ns/1ns
`include "aer_params.svh"

module half_readout
    import aer_pkg::*;
#(
    parameter int HALF_ID = 0               // 0 top, 1 bottom
)
(
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 enable_i,    // Readout enable from merger
    input  logic [`AER_HALF_ROWS*`AER_COLS-1:0]  pix_req_i,   // Index row*COLS + col
    input  logic                                 ev_take_i,   // Merger takes the offer
    output logic [`AER_HALF_ROWS*`AER_COLS-1:0]  pix_clr_o,   // One-cycle clear pulse
    output logic                                 ev_valid_o,  // Event offered
    output row_addr_t                            ev_row_o,    // Row of the offer
    output col_addr_t                            ev_col_o     // Column of the offer
);

    localparam int COLS = `AER_COLS;

    row_vec_t  row_req;                     // Rows with any pending pixel
    row_vec_t  row_gnt;                     // Granted row, one-hot
    row_addr_t row_addr;                    // Granted row, encoded
    logic      row_adv;                     // Ask the arbiter for the next row
    col_vec_t  row_pix;                     // Requests of the granted row
    col_vec_t  offer_cols;                  // Column currently offered
    col_vec_t  cand_cols;                   // Columns still to serve
    col_vec_t  cand_gnt;                    // Next column to offer
    col_vec_t  col_served_q;                // Columns served in this row visit
    col_vec_t  col_sel_q;                   // One-hot column of the offer
    logic      ev_valid_q;
    logic      taken;
    logic      load;

    // OR across columns gives the row request
    always_comb
    begin
        for (int r = 0; r < $bits(row_vec_t); r++)
            row_req[r] = |pix_req_i[r*COLS +: COLS];
    end

    row_arbiter u_row_arb
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (row_adv),
        .req_i         (row_req),
        .gnt_o         (row_gnt),
        .row_addr_o    (row_addr),
        .grp_release_o ()
    );

    assign row_pix    = (row_gnt != '0) ? pix_req_i[row_addr*COLS +: COLS] : '0;
    assign offer_cols = ev_valid_q ? col_sel_q : '0;
    assign cand_cols  = row_pix & ~col_served_q & ~offer_cols;  // Excludes the offer itself

    priority_arb #(.WIDTH(COLS)) u_col_pick
    (
        .req_i (cand_cols),
        .gnt_o (cand_gnt)
    );

    assign taken   = ev_valid_q && ev_take_i;
    assign load    = enable_i && (cand_cols != '0) && (!ev_valid_q || ev_take_i);
    assign row_adv = enable_i && !ev_valid_q && (cand_cols == '0);  // Row done or no grant

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ev_valid_q   <= 1'b0;
            col_served_q <= '0;
            pix_clr_o    <= '0;
        end
        else
        begin
            pix_clr_o <= '0;
            if (taken)
            begin
                col_served_q <= col_served_q | col_sel_q;
                pix_clr_o[row_addr*COLS +: COLS] <= col_sel_q;  // Clear exactly the read pixel
            end
            if (row_adv)
                col_served_q <= '0;         // New row visit
            if (load)
                ev_valid_q <= 1'b1;         // Next column follows right after a take
            else if (taken)
                ev_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (load)
            col_sel_q <= cand_gnt;
    end

    assign ev_valid_o = ev_valid_q;
    assign ev_row_o   = row_addr;           // Row is frozen while an offer is pending

    always_comb
    begin
        ev_col_o = '0;
        for (int c = 0; c < COLS; c++)
        begin
            if (col_sel_q[c])
                ev_col_o = col_addr_t'(c);
        end
    end

    a_clr_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(pix_clr_o))
        else $error("half %0d clears more than one pixel: %h", HALF_ID, pix_clr_o);

endmodule

/* event_merger.sv */
/*
  Merges the two half readouts into a single event register and exposes it
  over a Wishbone classic slave. There is no FIFO. While the register is full,
  no half is taken and the halves keep their offers.
  Address 0 read returns the event and empties the register at the ack;
  an empty register reads as all zero. Address 0 writes are ignored.
  Address 1 holds the enable bit. wb_ack_o is a single-cycle pulse.
*/
`timescale 1ns/1ns

module event_merger
    import aer_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      top_valid_i,          // Top half offer
    input  row_addr_t top_row_i,
    input  col_addr_t top_col_i,
    input  logic      bot_valid_i,          // Bottom half offer
    input  row_addr_t bot_row_i,
    input  col_addr_t bot_col_i,
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  logic      wb_adr_i,             // 0 event, 1 control
    input  wb_data_t  wb_dat_i,
    output logic      top_take_o,           // Take top offer this cycle
    output logic      bot_take_o,           // Take bottom offer this cycle
    output logic      enable_o,             // Readout enable to both halves
    output wb_data_t  wb_dat_o,
    output logic      wb_ack_o
);

    merge_state_t state_q;
    logic         bot_first_q;              // Bottom wins the next tie
    logic         enable_q;
    logic         ack_q;
    logic         ev_rd_q;                  // Acked access is an event read
    logic         wb_req;                   // New access arrives this cycle
    logic         ev_half_q;                // Event payload
    row_addr_t    ev_row_q;
    col_addr_t    ev_col_q;
    logic         is_empty;
    logic         rd_pop;                   // Event read acknowledged
    wb_data_t     ev_word;
    wb_data_t     ctrl_word;

    assign is_empty   = (state_q == MERGE_EMPTY);
    assign top_take_o = is_empty && top_valid_i && (!bot_valid_i || !bot_first_q);
    assign bot_take_o = is_empty && bot_valid_i && (!top_valid_i || bot_first_q);

    assign wb_req = wb_cyc_i && wb_stb_i && !ack_q;
    assign rd_pop = ev_rd_q && (state_q == MERGE_FULL);

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q     <= MERGE_EMPTY;
            bot_first_q <= 1'b0;            // Top wins the first tie
            enable_q    <= 1'b0;
            ack_q       <= 1'b0;
            ev_rd_q     <= 1'b0;
        end
        else
        begin
            ack_q   <= wb_req;              // One ack per strobe
            ev_rd_q <= wb_req && !wb_we_i && !wb_adr_i;
            if (wb_req && wb_we_i && wb_adr_i)
                enable_q <= wb_dat_i[0];    // Write lands as the access arrives
            case (state_q)
                MERGE_EMPTY:
                begin
                    if (top_take_o || bot_take_o)
                    begin
                        state_q     <= MERGE_FULL;
                        bot_first_q <= top_take_o;  // Other half gets the next tie
                    end
                end
                MERGE_FULL:
                begin
                    if (rd_pop)
                        state_q <= MERGE_EMPTY;
                end
                default: state_q <= MERGE_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (top_take_o)
        begin
            ev_half_q <= 1'b0;
            ev_row_q  <= top_row_i;
            ev_col_q  <= top_col_i;
        end
        else if (bot_take_o)
        begin
            ev_half_q <= 1'b1;
            ev_row_q  <= bot_row_i;
            ev_col_q  <= bot_col_i;
        end
    end

    // Fields read as zero while empty
    always_comb
    begin
        ev_word = '0;
        if (state_q == MERGE_FULL)
        begin
            ev_word[31]              = 1'b1;
            ev_word[8]               = ev_half_q;
            ev_word[4 +: $bits(row_addr_t)] = ev_row_q;
            ev_word[0 +: $bits(col_addr_t)] = ev_col_q;
        end
    end

    assign ctrl_word = wb_data_t'(enable_q);
    assign wb_dat_o  = !ack_q ? '0 : (wb_adr_i ? ctrl_word : ev_word);
    assign wb_ack_o  = ack_q;
    assign enable_o  = enable_q;

    a_one_take : assert property (@(posedge clk_i) disable iff (reset_i)
        !(top_take_o && bot_take_o))
        else $error("both halves taken in one cycle");

endmodule

/* aer_readout_top.sv */
/*
  Top level of the pixel readout arbiter.
  pixel_req_i bit index is half*16 + row*4 + col; bits 15..0 are the top half.
  Requests must hold until the matching pixel_clr_o pulse.
  Latency from request to event varies; software polls address 0 until
  bit 31 of the returned word is set.
*/
`timescale 1ns/1ns
`include "aer_params.svh"

module aer_readout_top
    import aer_pkg::*;
(
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic [2*`AER_HALF_ROWS*`AER_COLS-1:0]  pixel_req_i,  // Level requests
    output logic [2*`AER_HALF_ROWS*`AER_COLS-1:0]  pixel_clr_o,  // Clear pulses
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    input  logic                                   wb_we_i,
    input  logic                                   wb_adr_i,
    input  wb_data_t                               wb_dat_i,
    output wb_data_t                               wb_dat_o,
    output logic                                   wb_ack_o
);

    localparam int HALF_PIX = `AER_HALF_ROWS*`AER_COLS;

    logic      enable;                      // Shared readout enable
    logic      top_valid, bot_valid;
    logic      top_take, bot_take;
    row_addr_t top_row, bot_row;
    col_addr_t top_col, bot_col;

    half_readout #(.HALF_ID(0)) u_top
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable),
        .pix_req_i  (pixel_req_i[HALF_PIX-1:0]),
        .ev_take_i  (top_take),
        .pix_clr_o  (pixel_clr_o[HALF_PIX-1:0]),
        .ev_valid_o (top_valid),
        .ev_row_o   (top_row),
        .ev_col_o   (top_col)
    );

    half_readout #(.HALF_ID(1)) u_bot
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable),
        .pix_req_i  (pixel_req_i[2*HALF_PIX-1:HALF_PIX]),
        .ev_take_i  (bot_take),
        .pix_clr_o  (pixel_clr_o[2*HALF_PIX-1:HALF_PIX]),
        .ev_valid_o (bot_valid),
        .ev_row_o   (bot_row),
        .ev_col_o   (bot_col)
    );

    event_merger u_merge
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .top_valid_i (top_valid),
        .top_row_i   (top_row),
        .top_col_i   (top_col),
        .bot_valid_i (bot_valid),
        .bot_row_i   (bot_row),
        .bot_col_i   (bot_col),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .top_take_o  (top_take),
        .bot_take_o  (bot_take),
        .enable_o    (enable),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o)
    );

endmodule

/* tb_aer_readout_top.sv */
/*
  Testbench for the AER readout top level.
  Expected order follows the round rules. Rows and then columns ascend per half,
  and the halves alternate with the tie going to the half not served last.
  Reads are spaced so that both halves have re-offered before the merger empties.
  Late pixels are only used in a top-only entry and land in a later round.
*/
`timescale 1ns/1ns
`include "aer_params.svh"

module tb_aer_readout_top;

    localparam int NUM_ENTRIES = 10;
    localparam int CLK_PERIOD  = 40;
    localparam int GAP         = 6;        // Idle cycles before each event read

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic [31:0] pix;                      // Pixel model, drives pixel_req_i
    logic [31:0] pixel_clr_o;
    logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i;
    logic [31:0] wb_dat_i, wb_dat_o;
    logic        wb_ack_o;

    logic [31:0] set_tab [NUM_ENTRIES];    // Pixels set at entry start
    logic [31:0] late_tab[NUM_ENTRIES];    // Pixels set after the first read
    logic        en_tab  [NUM_ENTRIES];
    int          stall_tab[NUM_ENTRIES];   // Host pause after the first read
    int          cnt_tab [NUM_ENTRIES];    // Expected event count, -1 if random

    logic [31:0] exp_q[$], top_q[$], bot_q[$];
    logic        bot_first;                // Bottom wins the next tie
    logic [31:0] exp_pend;                 // Pixels pending while disabled
    logic [31:0] add_mask;
    logic        add_tog, add_seen;
    int          clr_count, errors, checks;

    aer_readout_top DUT
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pixel_req_i (pix),
        .pixel_clr_o (pixel_clr_o),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // Pixel model clears on a pulse and sets on request from the stimulus
    always @(posedge clk_i)
    begin
        #2;
        if ((pixel_clr_o & ~pix) != '0)
        begin
            errors++;
            $display("[ERROR] %0t ns: clear of idle pixel %h", $time, pixel_clr_o);
        end
        if (pixel_clr_o != '0)
            clr_count++;
        pix = pix & ~pixel_clr_o;
        if (add_tog != add_seen)
        begin
            pix      = pix | add_mask;
            add_seen = add_tog;
        end
    end

    initial
    begin
        #(NUM_ENTRIES*200*CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // One row of the stimulus table
    task automatic fill_entry(input int i, input logic [31:0] set_pat,
                              input logic [31:0] late_pat, input logic en,
                              input int stall, input int cnt);
        set_tab[i]   = set_pat;
        late_tab[i]  = late_pat;
        en_tab[i]    = en;
        stall_tab[i] = stall;
        cnt_tab[i]   = cnt;
    endtask

    task automatic set_pixels(input logic [31:0] m);
        @(posedge clk_i);
        #1;
        add_mask = m;
        add_tog  = ~add_tog;
        @(posedge clk_i);
    endtask

    task automatic wb_cycle(input logic we, input logic adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge clk_i);
        #2;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        do
        begin
            @(posedge clk_i);
            #2;
            n++;
        end
        while (!wb_ack_o && n < 20);
        if (!wb_ack_o)
        begin
            errors++;
            $display("Wishbone cycle at %0t ns got no ack", $time);
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    // Poll address 0 until the valid bit shows up
    task automatic read_event(output logic [31:0] w);
        int n;
        n = 0;
        do
        begin
            wb_cycle(1'b0, 1'b0, '0, w);
            n++;
        end
        while (!w[31] && n < 30);
        if (!w[31])
        begin
            errors++;
            $display("No event arrived after polling at %0t ns", $time);
        end
    endtask

    // Round order per half first, then the alternating merge
    task automatic predict(input logic [31:0] base, input logic [31:0] late);
        logic [31:0] pat;
        logic [31:0] w;
        for (int p = 0; p < 2; p++)
        begin
            pat = (p == 0) ? base : late;
            for (int h = 0; h < 2; h++)
                for (int r = 0; r < 4; r++)
                    for (int c = 0; c < 4; c++)
                        if (pat[h*16 + r*4 + c])
                        begin
                            w = 32'h8000_0000 | (h << 8) | (r << 4) | c;
                            if (h == 0)
                                top_q.push_back(w);
                            else
                                bot_q.push_back(w);
                        end
        end
        while (top_q.size() != 0 || bot_q.size() != 0)
        begin
            if (top_q.size() != 0 && (bot_q.size() == 0 || !bot_first))
            begin
                exp_q.push_back(top_q.pop_front());
                bot_first = 1'b1;
            end
            else
            begin
                exp_q.push_back(bot_q.pop_front());
                bot_first = 1'b0;
            end
        end
    endtask

    initial
    begin
        logic [31:0] d, pend;
        int          clr0, n_ev;
        d = $urandom(32'h0986b9c3);
        pix       = '0;
        add_mask  = '0;
        add_tog   = 1'b0;
        add_seen  = 1'b0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = 1'b0;
        wb_dat_i  = '0;
        reset_i   = 1'b1;
        errors    = 0;
        checks    = 0;
        clr_count = 0;
        bot_first = 1'b0;
        exp_pend  = '0;

        // Directed entries come first and random ones follow
        fill_entry(0, 32'h0800_0002, '0,     1'b0, 0,   0);
        fill_entry(1, '0,            '0,     1'b1, 0,   2);
        fill_entry(2, 32'h0000_0902, 32'h42, 1'b1, 0,   5);
        fill_entry(3, 32'h8421_0013, '0,     1'b1, 0,   7);
        fill_entry(4, 32'h1234_8421, '0,     1'b1, 150, 9);  // Host stalls with the merger full
        for (int i = 5; i < NUM_ENTRIES; i++)
            fill_entry(i, $urandom() & $urandom(), '0, 1'b1, 0, -1);

        repeat (3) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        wb_cycle(1'b0, 1'b0, '0, d);
        check_word("event after reset", d, '0);
        wb_cycle(1'b0, 1'b1, '0, d);
        check_word("control after reset", d, '0);

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            pend = exp_pend | set_tab[i];
            clr0 = clr_count;              // Halves may start as soon as pixels appear
            if (set_tab[i] != '0)
                set_pixels(set_tab[i]);
            wb_cycle(1'b1, 1'b1, {31'b0, en_tab[i]}, d);
            wb_cycle(1'b0, 1'b1, '0, d);
            check_word("control readback", d, {31'b0, en_tab[i]});
            if (!en_tab[i])
            begin
                repeat (20) @(posedge clk_i);
                check_word("clears while disabled", clr_count - clr0, 0);
                wb_cycle(1'b0, 1'b0, '0, d);
                check_word("event while disabled", d, '0);
                exp_pend = pend;
            end
            else
            begin
                exp_q.delete();
                predict(pend, late_tab[i]);
                exp_pend = '0;
                n_ev = exp_q.size();
                if (cnt_tab[i] >= 0)
                    check_word("predicted count", n_ev, cnt_tab[i]);
                for (int k = 0; k < n_ev; k++)
                begin
                    repeat (GAP) @(posedge clk_i);
                    read_event(d);
                    check_word($sformatf("entry %0d event %0d", i, k), d, exp_q[k]);
                    if (k == 0 && late_tab[i] != '0)
                        set_pixels(late_tab[i]);
                    if (k == 0)
                        repeat (stall_tab[i]) @(posedge clk_i);
                end
                repeat (GAP) @(posedge clk_i);
                wb_cycle(1'b0, 1'b0, '0, d);
                check_word("read after drain", d, '0);
                check_word("pixels left", pix, '0);
                check_word("clear pulses", clr_count - clr0, n_ev);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* aer_readout_top.f */
+incdir+.
aer_pkg.sv
priority_arb.sv
row_arbiter.sv
half_readout.sv
event_merger.sv
aer_readout_top.sv
tb_aer_readout_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile the AER readout with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f aer_readout_top.f \
    --top-module tb_aer_readout_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
